// File: flash_settings.svh
`ifndef FLASH_SETTINGS_SVH
`define FLASH_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// parallel host port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define FLASH_WORD_ADDR_W 17
`define FLASH_DATA_W      16

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// serial flash side
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define SPI_ADDR_W      24
`define SPI_READ_OPCODE 8'h03
`define SPI_DIV_W       4

// the image sits near the top of a 64 Mbit part by default.
`define CFG_BASE_RESET 24'h7E0000
`define CFG_DIV_RESET  4'd1

`endif

// File: flash_pkg.sv
`include "flash_settings.svh"

package flash_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // asynchronous NOR-style read port as seen from the host.
    typedef struct packed {
        logic                          ce_n;
        logic                          oe_n;
        logic [`FLASH_WORD_ADDR_W-1:0] addr;
    } host_bus_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bridge internals
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic [`SPI_ADDR_W-1:0] base;
        logic [`SPI_DIV_W-1:0]  clk_div;
    } cfg_t;

    // serial byte address of the word being fetched.
    typedef struct packed {
        logic [`SPI_ADDR_W-1:0] addr;
    } fetch_req_t;

    // outputs toward the serial flash, miso travels on its own.
    typedef struct packed {
        logic csn;
        logic sclk;
        logic mosi;
    } spi_pins_t;

endpackage

// File: bridge_config.sv
`include "flash_settings.svh"

module bridge_config (
    input  logic                   SIM_CLK,
    input  logic                   rst_n,
    input  logic                   cfg_we,
    input  logic                   cfg_sel,
    input  logic [23:0]            cfg_wdata,
    output flash_pkg::cfg_t        cfg
);

    localparam logic SEL_BASE = 1'b0;
    localparam logic SEL_DIV  = 1'b1;

    logic [`SPI_ADDR_W-1:0] base_q;
    logic [`SPI_DIV_W-1:0]  clk_div_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register file
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // base of the image inside the serial flash.
    always_ff @(posedge SIM_CLK) begin
        if (!rst_n) begin
            base_q <= `CFG_BASE_RESET;
        end else if (cfg_we && cfg_sel == SEL_BASE) begin
            base_q <= cfg_wdata[`SPI_ADDR_W-1:0];
        end
    end

    // the divider only keeps its low bits, the rest of the write is dropped.
    always_ff @(posedge SIM_CLK) begin
        if (!rst_n) begin
            clk_div_q <= `CFG_DIV_RESET;
        end else if (cfg_we && cfg_sel == SEL_DIV) begin
            clk_div_q <= cfg_wdata[`SPI_DIV_W-1:0];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // outputs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the engine samples the divider at the start of each fetch, so a
    // write here never disturbs a transfer that is already running.
    assign cfg.base    = base_q;
    assign cfg.clk_div = clk_div_q;

endmodule

// File: bus_front.sv
`include "flash_settings.svh"

module bus_front (
    input  logic                       SIM_CLK,
    input  logic                       rst_n,
    input  flash_pkg::host_bus_t       host,
    input  logic [`SPI_ADDR_W-1:0]     base,
    input  logic                       busy,
    output logic                       fetch_start,
    output flash_pkg::fetch_req_t      fetch_req,
    input  logic                       fetch_done,
    input  logic [`FLASH_DATA_W-1:0]   fetch_word,
    output logic [`FLASH_DATA_W-1:0]   dq,
    output logic                       data_valid
);

    localparam int PAD_W = `SPI_ADDR_W - `FLASH_WORD_ADDR_W - 1;

    logic                     ce_prev_n;
    logic                     new_access;
    logic [`SPI_ADDR_W-1:0]   byte_addr;
    logic [`FLASH_DATA_W-1:0] word_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // access detection
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // a new access is the first sample with ce_n low. holding ce_n low
    // afterwards does not start another fetch.
    assign new_access = !host.ce_n && ce_prev_n;

    // words are two bytes wide in the serial flash.
    assign byte_addr = base + {{PAD_W{1'b0}}, host.addr, 1'b0};

    always_ff @(posedge SIM_CLK) begin
        if (!rst_n) begin
            ce_prev_n <= 1'b1;
        end else begin
            ce_prev_n <= host.ce_n;
        end
    end

    always_ff @(posedge SIM_CLK) begin
        if (!rst_n) begin
            fetch_start <= 1'b0;
        end else begin
            fetch_start <= new_access && !busy;
        end
    end

    always_ff @(posedge SIM_CLK) begin
        if (new_access && !busy) begin
            fetch_req.addr <= byte_addr;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // returned word
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // data_valid falls together with the start pulse and comes back
    // once the engine hands over the word.
    always_ff @(posedge SIM_CLK) begin
        if (!rst_n) begin
            data_valid <= 1'b0;
        end else if (new_access && !busy) begin
            data_valid <= 1'b0;
        end else if (fetch_done) begin
            data_valid <= 1'b1;
        end
    end

    always_ff @(posedge SIM_CLK) begin
        if (fetch_done) begin
            word_q <= fetch_word;
        end
    end

    // no tri-state here, an idle bus reads as zero.
    assign dq = (data_valid && !host.oe_n) ? word_q : '0;

endmodule

// File: spi_read_engine.sv
`include "flash_settings.svh"

module spi_read_engine (
    input  logic                      SIM_CLK,
    input  logic                      rst_n,
    input  logic                      fetch_start,
    input  flash_pkg::fetch_req_t     fetch_req,
    input  logic [`SPI_DIV_W-1:0]     clk_div,
    output logic                      busy,
    output flash_pkg::spi_pins_t      spi,
    input  logic                      miso,
    output logic                      fetch_done,
    output logic [`FLASH_DATA_W-1:0]  fetch_word
);

    localparam int         CMD_BITS    = 8 + `SPI_ADDR_W;
    localparam int         DATA_BITS   = `FLASH_DATA_W;
    localparam logic [7:0] READ_OPCODE = `SPI_READ_OPCODE;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CMD,
        ST_DATA
    } state_t;

    state_t                   state;
    logic                     csn_q;
    logic                     sclk_q;
    logic                     mosi_q;
    logic [`SPI_DIV_W-1:0]    div_q;
    logic [`SPI_DIV_W-1:0]    div_cnt;
    logic [4:0]               bit_cnt;
    logic [CMD_BITS-1:0]      cmd_sr;
    logic [DATA_BITS-1:0]     rx_sr;
    logic                     half_tick;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // clock divider
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // each half period of sclk is div_q+1 system clocks.
    assign half_tick = (div_cnt == div_q);

    always_ff @(posedge SIM_CLK) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (state == ST_IDLE || half_tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // transfer FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // this is SPI mode 0. mosi moves on the falling edge and miso is taken
    // on the rising edge. the command goes out MSB first, opcode then byte address.
    always_ff @(posedge SIM_CLK) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            csn_q      <= 1'b1;
            sclk_q     <= 1'b0;
            mosi_q     <= 1'b0;
            bit_cnt    <= '0;
            fetch_done <= 1'b0;
        end else begin
            fetch_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (fetch_start) begin
                        state   <= ST_CMD;
                        csn_q   <= 1'b0;
                        mosi_q  <= READ_OPCODE[7];
                        bit_cnt <= '0;
                    end
                end
                ST_CMD: begin
                    if (half_tick) begin
                        sclk_q <= !sclk_q;
                        if (sclk_q) begin
                            if (bit_cnt == 5'(CMD_BITS - 1)) begin
                                state   <= ST_DATA;
                                mosi_q  <= 1'b0;
                                bit_cnt <= '0;
                            end else begin
                                mosi_q  <= cmd_sr[CMD_BITS-2];
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end
                    end
                end
                ST_DATA: begin
                    if (half_tick) begin
                        sclk_q <= !sclk_q;
                        if (sclk_q) begin
                            if (bit_cnt == 5'(DATA_BITS - 1)) begin
                                // the last high phase ends here and the flash is deselected.
                                state      <= ST_IDLE;
                                csn_q      <= 1'b1;
                                fetch_done <= 1'b1;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                    csn_q <= 1'b1;
                end
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // shift registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the divider is latched with the command so a config write
    // during a transfer only affects later ones.
    always_ff @(posedge SIM_CLK) begin
        if (state == ST_IDLE && fetch_start) begin
            cmd_sr <= {READ_OPCODE, fetch_req.addr};
            div_q  <= clk_div;
        end else if (state == ST_CMD && half_tick && sclk_q) begin
            cmd_sr <= {cmd_sr[CMD_BITS-2:0], 1'b0};
        end
    end

    // first bit in ends up at the top, so the first byte is bits 15..8.
    always_ff @(posedge SIM_CLK) begin
        if (state == ST_DATA && half_tick && !sclk_q) begin
            rx_sr <= {rx_sr[DATA_BITS-2:0], miso};
        end
    end

    assign busy       = (state != ST_IDLE);
    assign fetch_word = rx_sr;
    assign spi.csn    = csn_q;
    assign spi.sclk   = sclk_q;
    assign spi.mosi   = mosi_q;

endmodule

// File: parallel_flash_bridge.sv
`include "flash_settings.svh"

module parallel_flash_bridge (
    input  logic                      SIM_CLK,
    input  logic                      rst_n,
    input  flash_pkg::host_bus_t      host,
    input  logic                      cfg_we,
    input  logic                      cfg_sel,
    input  logic [23:0]               cfg_wdata,
    input  logic                      miso,
    output flash_pkg::spi_pins_t      spi,
    output logic [`FLASH_DATA_W-1:0]  dq,
    output logic                      data_valid
);

    import flash_pkg::*;

    cfg_t                     cfg;
    fetch_req_t               fetch_req;
    logic                     fetch_start;
    logic                     fetch_done;
    logic                     busy;
    logic [`FLASH_DATA_W-1:0] fetch_word;

    bridge_config bridge_config_i (
        .SIM_CLK   (SIM_CLK),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_sel   (cfg_sel),
        .cfg_wdata (cfg_wdata),
        .cfg       (cfg)
    );

    bus_front bus_front_i (
        .SIM_CLK     (SIM_CLK),
        .rst_n       (rst_n),
        .host        (host),
        .base        (cfg.base),
        .busy        (busy),
        .fetch_start (fetch_start),
        .fetch_req   (fetch_req),
        .fetch_done  (fetch_done),
        .fetch_word  (fetch_word),
        .dq          (dq),
        .data_valid  (data_valid)
    );

    spi_read_engine spi_read_engine_i (
        .SIM_CLK     (SIM_CLK),
        .rst_n       (rst_n),
        .fetch_start (fetch_start),
        .fetch_req   (fetch_req),
        .clk_div     (cfg.clk_div),
        .busy        (busy),
        .spi         (spi),
        .miso        (miso),
        .fetch_done  (fetch_done),
        .fetch_word  (fetch_word)
    );

endmodule

// File: spi_flash_model.sv
`include "flash_settings.svh"

module spi_flash_model (
    input  flash_pkg::spi_pins_t spi,
    output logic                 miso,
    output int                   bad_opcodes
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CMD_BITS = 8 + `SPI_ADDR_W;

    logic                csn;
    logic                sclk;
    logic                miso_q = 1'b0;
    logic [CMD_BITS-1:0] cmd_sr;
    logic [7:0]          tx_byte;
    int                  cmd_cnt = 0;
    int                  tx_cnt = 0;

    assign csn  = spi.csn;
    assign sclk = spi.sclk;
    assign miso = miso_q;

    // the stored byte at serial address b is the XOR of its three address bytes.
    function automatic logic [7:0] byte_at(input logic [`SPI_ADDR_W-1:0] b);
        return b[23:16] ^ b[15:8] ^ b[7:0];
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // command and data phases
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // opcode and address come in on rising sclk, MSB first.
    always @(posedge sclk or posedge csn) begin
        if (csn) begin
            cmd_cnt <= 0;
        end else if (cmd_cnt < CMD_BITS) begin
            cmd_sr  <= {cmd_sr[CMD_BITS-2:0], spi.mosi};
            cmd_cnt <= cmd_cnt + 1;
        end
    end

    // read data leaves on falling sclk, one byte after another from the address.
    always @(negedge sclk or posedge csn) begin
        if (csn) begin
            tx_cnt <= 0;
            miso_q <= 1'b0;
        end else if (cmd_cnt == CMD_BITS) begin
            if (tx_cnt == 0) begin
                assert (cmd_sr[CMD_BITS-1 -: 8] == `SPI_READ_OPCODE) else begin
                    $display("flash model: opcode %02h is not a read command",
                             cmd_sr[CMD_BITS-1 -: 8]);
                    bad_opcodes <= bad_opcodes + 1;
                end
            end
            tx_byte = byte_at(cmd_sr[`SPI_ADDR_W-1:0] + `SPI_ADDR_W'(tx_cnt / 8));
            miso_q <= tx_byte[7 - (tx_cnt % 8)];
            tx_cnt <= tx_cnt + 1;
        end
    end

endmodule

// File: tb_parallel_flash_bridge.sv
`include "flash_settings.svh"

module tb_parallel_flash_bridge;

    timeunit 1ns;
    timeprecision 1ps;

    import flash_pkg::*;

    localparam int WAIT_LIMIT = 4000;

    logic                     SIM_CLK;
    logic                     rst_n;
    host_bus_t                host;
    logic                     cfg_we;
    logic                     cfg_sel;
    logic [23:0]              cfg_wdata;
    logic                     miso;
    spi_pins_t                spi;
    logic [`FLASH_DATA_W-1:0] dq;
    logic                     data_valid;
    int                       bad_opcodes;
    int                       error_count = 0;
    int                       check_count = 0;
    bit                       aborted = 1'b0;
    logic [`SPI_DIV_W-1:0]    div_model = `CFG_DIV_RESET;

    parallel_flash_bridge parallel_flash_bridge_i (
        .SIM_CLK    (SIM_CLK),
        .rst_n      (rst_n),
        .host       (host),
        .cfg_we     (cfg_we),
        .cfg_sel    (cfg_sel),
        .cfg_wdata  (cfg_wdata),
        .miso       (miso),
        .spi        (spi),
        .dq         (dq),
        .data_valid (data_valid)
    );

    spi_flash_model spi_flash_model_i (
        .spi         (spi),
        .miso        (miso),
        .bad_opcodes (bad_opcodes)
    );

    always #5 SIM_CLK = !SIM_CLK;

    task automatic expect_value(input string name, input logic [23:0] expected,
                                input logic [23:0] actual);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host operations
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // called and left one ns after a rising edge.
    task automatic write_config(input logic sel, input logic [23:0] value);
        cfg_sel   = sel;
        cfg_wdata = value;
        cfg_we    = 1'b1;
        @(posedge SIM_CLK);
        #1;
        cfg_we = 1'b0;
        if (sel) begin
            div_model = value[`SPI_DIV_W-1:0];
        end
    endtask

    task automatic run_read(input logic [16:0] addr, input logic oe_n,
                            input logic [15:0] expected);
        int    cycles;
        int    high_run;
        int    csn_falls;
        logic  csn_prev;
        string name;
        name      = $sformatf("read %05h", addr);
        cycles    = 0;
        high_run  = 0;
        csn_falls = 0;
        csn_prev  = 1'b1;
        host.ce_n = 1'b1;
        host.addr = addr;
        host.oe_n = oe_n;
        @(posedge SIM_CLK);
        #1;
        host.ce_n = 1'b0;
        @(posedge SIM_CLK);
        // every sclk high phase is timed while the fetch runs.
        do begin
            @(negedge SIM_CLK);
            cycles++;
            if (spi.sclk) begin
                high_run++;
            end else if (high_run != 0) begin
                expect_value({name, " sclk high"}, 24'(div_model) + 24'd1, 24'(high_run));
                high_run = 0;
            end
            if (csn_prev && !spi.csn) begin
                csn_falls++;
            end
            csn_prev = spi.csn;
        end while (!data_valid && cycles < WAIT_LIMIT);
        if (!data_valid) begin
            $display("timeout: data_valid never rose during %s", name);
            aborted = 1'b1;
        end else begin
            // ce_n stays low for as long again, with oe_n lowered halfway when it was high.
            for (int i = 0; i < cycles + 8; i++) begin
                @(posedge SIM_CLK);
                #1;
                if (i == cycles / 2) begin
                    host.oe_n = 1'b0;
                end
                @(negedge SIM_CLK);
                expect_value({name, " dq"}, host.oe_n ? 24'd0 : 24'(expected), 24'(dq));
                if (csn_prev && !spi.csn) begin
                    csn_falls++;
                end
                csn_prev = spi.csn;
            end
            expect_value({name, " csn low periods"}, 24'd1, 24'(csn_falls));
            @(posedge SIM_CLK);
            #1;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int          fd;
        int          n;
        string       line;
        logic [23:0] f1;
        logic [23:0] f2;
        logic [23:0] f3;
        SIM_CLK   = 1'b0;
        rst_n     = 1'b0;
        host.ce_n = 1'b1;
        host.oe_n = 1'b0;
        host.addr = '0;
        cfg_we    = 1'b0;
        cfg_sel   = 1'b0;
        cfg_wdata = '0;
        @(posedge SIM_CLK);
        @(negedge SIM_CLK);
        expect_value("reset csn", 24'd1, 24'(spi.csn));
        expect_value("reset sclk", 24'd0, 24'(spi.sclk));
        expect_value("reset data_valid", 24'd0, 24'(data_valid));
        expect_value("reset dq", 24'd0, 24'(dq));
        repeat (3) @(posedge SIM_CLK);
        #1;
        rst_n = 1'b1;
        fd = $fopen("flash_trace.txt", "r");
        if (fd == 0) begin
            $display("the trace file flash_trace.txt could not be opened");
            aborted = 1'b1;
        end
        while (fd != 0 && !aborted && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 2) begin
                if (line[0] == "W") begin
                    n = $sscanf(line.substr(2, line.len() - 1), "%h %h", f1, f2);
                    write_config(f1[0], f2);
                end else if (line[0] == "R") begin
                    n = $sscanf(line.substr(2, line.len() - 1), "%h %h %h", f1, f2, f3);
                    run_read(f1[16:0], f2[0], f3[15:0]);
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("checks: %0d, errors: %0d, flash model opcode errors: %0d",
                 check_count, error_count, bad_opcodes);
        if (error_count == 0 && bad_opcodes == 0 && !aborted) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: flash_trace.txt
# W <sel> <value>: config write, sel 0 = image base, sel 1 = SPI clock divider
# R <word addr> <oe_n> <expected dq>: dq = {f(b), f(b+1)}, b = base + 2*addr, f = XOR of b's bytes
R 00000 0 7e7f
R 00001 0 7c7d
R 01234 0 3233
R 03001 0 1c1d
R 1ffff 0 8081
R 01234 1 3233
W 0 123456
R 00000 0 7071
R 00100 0 7273
R 1ffff 0 7677
W 1 000013
R 00042 0 fcfd
R 1ffff 1 7677
W 0 fffff0
R 1ffff 0 1213

// File: flist.f
+incdir+.
flash_pkg.sv
bridge_config.sv
bus_front.sv
spi_read_engine.sv
parallel_flash_bridge.sv
spi_flash_model.sv
tb_parallel_flash_bridge.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_parallel_flash_bridge \
    -f flist.f -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "Finished with no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
